/* Bender.yml */
package:
  name: rv_mini_core

sources:
  - files:
      - design/rv_core_pkg.sv
      - design/rv_core_if.sv
      - design/rv_fetch_unit.sv
      - design/rv_regfile.sv
      - design/rv_decode_exec.sv
      - design/rv_load_store_unit.sv
      - design/rv_mini_core.sv
  - target: test
    files:
      - bench/tb_rv_mini_core_sva.sv
      - bench/tb_rv_mini_core.sv

/* bench/tb_rv_mini_core.sv */
////////////////////
// Testbench for rv_mini_core with random program, memory models and reference model
// Branches only jump forward, so the run always reaches the halt loop
// Load data is drawn by the model up front and replayed by the data memory
// Grant waits 0..3 cycles, rvalid 1..4 cycles after grant, on both ports
////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_rv_mini_core
  import rv_core_pkg::*;
();

  localparam int unsigned     PROG_LEN  = 60;
  localparam logic [XLEN-1:0] BOOT_ADDR = 32'h0000_0080;
  localparam logic [XLEN-1:0] HALT_ADDR = BOOT_ADDR + PROG_LEN * 4;
  localparam logic [15:0]     SEED      = 16'd30173;
  // Per instruction: fetch up to 10 cycles, data access up to 11
  localparam int unsigned     TIMEOUT_CYCLES = (PROG_LEN + 2) * 24 + 40;

  logic            clk = 1'b0;
  logic            rst_n;
  logic [XLEN-1:0] boot_addr_i;
  logic            fetch_enable_i;
  logic            instr_req_o, instr_gnt_i, instr_rvalid_i;
  logic [XLEN-1:0] instr_addr_o, instr_rdata_i;
  logic            data_req_o, data_we_o, data_gnt_i, data_rvalid_i;
  logic [XLEN-1:0] data_addr_o, data_wdata_o, data_rdata_i;
  logic            core_busy_o;

  logic [15:0]     lfsr_q = SEED;
  rv_instr_u       prog [0:PROG_LEN];    // Last entry is the halt loop
  logic [XLEN-1:0] m_regs [0:31];        // Model register file
  logic [XLEN-1:0] exp_fetch_q [$];      // Expected fetch addresses
  logic            exp_we_q [$];         // Expected data accesses, in order
  logic [XLEN-1:0] exp_addr_q [$];
  logic [XLEN-1:0] exp_wdata_q [$];
  logic [XLEN-1:0] load_data_q [$];      // Random words returned by loads
  logic            halt_seen = 1'b0;
  int unsigned     cycle_cnt = 0;

  always #2 clk = ~clk;  // 4 ns period

  rv_mini_core dut_i (.*);

  ////////////////////
  // Helpers
  ////////////////////
  // 16-bit Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_addr(input string name, input logic [XLEN-1:0] exp_val,
                            input logic [XLEN-1:0] act_val);
    if (act_val !== exp_val)
      report_fail($sformatf("** Error: %s expected %08h actual %08h", name, exp_val, act_val));
  endtask

  task automatic check_word(input string name, input logic [XLEN-1:0] exp_val,
                            input logic [XLEN-1:0] act_val);
    if (act_val !== exp_val)
      report_fail($sformatf("** Error: %s expected %08h actual %08h", name, exp_val, act_val));
  endtask

  task automatic check_bit(input string name, input logic exp_val, input logic act_val);
    if (act_val !== exp_val)
      report_fail($sformatf("** Error: %s expected %0b actual %0b", name, exp_val, act_val));
  endtask

  function automatic logic [XLEN-1:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic logic [XLEN-1:0] alu_model(input alu_op_e op, input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_XOR: return a ^ b;
      ALU_OR:  return a | b;
      ALU_AND: return a & b;
      default: return b;  // Pass through for LUI
    endcase
  endfunction

  function automatic void model_write(input logic [4:0] rd, input logic [XLEN-1:0] val);
    if (rd != 5'd0)  // x0 stays zero
      m_regs[rd] = val;
  endfunction

  function automatic logic [XLEN-1:0] fetch_word(input logic [XLEN-1:0] addr);
    logic [XLEN-1:0] idx;
    idx = (addr - BOOT_ADDR) >> 2;
    if (idx <= PROG_LEN)
      return prog[idx];
    else
      return {12'd0, 5'd0, F3_ADD_SUB, 5'd0, OPC_OPIMM};  // NOP outside the program
  endfunction

  ////////////////////
  // Program generator and reference model
  ////////////////////
  task automatic build_program();
    rv_instr_u   ins;
    logic [3:0]  kind;
    logic [4:0]  rd, rs1, rs2;
    logic [11:0] imm;
    logic [12:0] boff;
    int unsigned span;
    for (int i = 0; i < PROG_LEN; i++)
    begin
      kind = 4'(rand_bits(4));
      rd   = 5'(rand_bits(3));  // x0..x7, dense reuse, x0 included
      rs1  = 5'(rand_bits(3));
      rs2  = 5'(rand_bits(3));
      imm  = 12'(rand_bits(12));
      case (kind)
        4'd0, 4'd1: ins = {20'(rand_bits(20)), rd, OPC_LUI};
        4'd2, 4'd3: ins.i_fmt = {imm, rs1, F3_ADD_SUB, rd, OPC_OPIMM};
        4'd4:       ins.r_fmt = {7'b0, rs2, rs1, F3_ADD_SUB, rd, OPC_OP};
        4'd5:       ins.r_fmt = {F7_SUB, rs2, rs1, F3_ADD_SUB, rd, OPC_OP};
        4'd6:       ins.r_fmt = {7'b0, rs2, rs1, F3_XOR, rd, OPC_OP};
        4'd7:       ins.r_fmt = {7'b0, rs2, rs1, F3_OR, rd, OPC_OP};
        4'd8:       ins.r_fmt = {7'b0, rs2, rs1, F3_AND, rd, OPC_OP};
        4'd9, 4'd10:
        begin
          if (rand_bits(1) != 0)
            rs2 = rs1;  // Equal operands, so both outcomes occur
          span = 1 + rand_bits(2);
          if (span > PROG_LEN - i)
            span = PROG_LEN - i;  // Never past the halt
          boff = 13'(span * 4);
          ins.b_fmt = {boff[12], boff[10:5], rs2, rs1, (kind == 4'd9) ? F3_BEQ : F3_BNE,
                       boff[4:1], boff[11], OPC_BRANCH};
        end
        4'd11:      ins.i_fmt = {imm, rs1, F3_WORD, rd, OPC_LOAD};
        default:    ins.s_fmt = {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OPC_STORE};
      endcase
      prog[i] = ins;
    end
    prog[PROG_LEN] = {1'b0, 6'b0, 5'd0, 5'd0, F3_BEQ, 4'b0, 1'b0, OPC_BRANCH};  // BEQ x0, x0, 0
  endtask

  task automatic run_model();
    logic [XLEN-1:0] pc, nxt, a, b, word, bimm, val;
    rv_instr_u       ins;
    alu_op_e         op;
    for (int r = 0; r < 32; r++)
      m_regs[r] = '0;
    pc = BOOT_ADDR;
    exp_fetch_q.push_back(pc);
    while (pc != HALT_ADDR)
    begin
      ins  = prog[(pc - BOOT_ADDR) >> 2];
      word = ins;
      a    = m_regs[ins.r_fmt.rs1];
      b    = m_regs[ins.r_fmt.rs2];
      nxt  = pc + 4;
      case (ins.r_fmt.opcode)
        OPC_LUI:   model_write(ins.r_fmt.rd, alu_model(ALU_PASS_B, a, {word[31:12], 12'b0}));
        OPC_OPIMM: model_write(ins.i_fmt.rd, alu_model(ALU_ADD, a, sext12(ins.i_fmt.imm)));
        OPC_OP:
        begin
          case (ins.r_fmt.funct3)
            F3_XOR:  op = ALU_XOR;
            F3_OR:   op = ALU_OR;
            F3_AND:  op = ALU_AND;
            default: op = (ins.r_fmt.funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
          endcase
          model_write(ins.r_fmt.rd, alu_model(op, a, b));
        end
        OPC_BRANCH:
        begin
          bimm = {{19{ins.b_fmt.imm12}}, ins.b_fmt.imm12, ins.b_fmt.imm11,
                  ins.b_fmt.imm10_5, ins.b_fmt.imm4_1, 1'b0};
          if ((ins.b_fmt.funct3 == F3_BEQ) ? (a == b) : (a != b))
            nxt = pc + bimm;
        end
        OPC_LOAD:
        begin
          val = rand_bits(32);
          load_data_q.push_back(val);
          exp_we_q.push_back(1'b0);
          exp_addr_q.push_back(a + sext12(ins.i_fmt.imm));
          exp_wdata_q.push_back('0);
          model_write(ins.i_fmt.rd, val);
        end
        OPC_STORE:
        begin
          exp_we_q.push_back(1'b1);
          exp_addr_q.push_back(a + sext12({ins.s_fmt.imm_hi, ins.s_fmt.imm_lo}));
          exp_wdata_q.push_back(b);
        end
        default: ;
      endcase
      pc = nxt;
      exp_fetch_q.push_back(pc);
    end
  endtask

  ////////////////////
  // Instruction memory
  ////////////////////
  initial
  begin : imem_model
    int unsigned     gnt_wait;
    int unsigned     rv_wait;
    int unsigned     fetch_n;
    logic [XLEN-1:0] req_addr;
    gnt_wait       = 0;
    rv_wait        = 0;
    fetch_n        = 0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    forever
    begin
      @(posedge clk);
      #1;
      instr_gnt_i    = 1'b0;
      instr_rvalid_i = 1'b0;
      if (rv_wait != 0)  // Granted, data pending
      begin
        rv_wait--;
        if (rv_wait == 0)
        begin
          instr_rvalid_i = 1'b1;
          instr_rdata_i  = fetch_word(req_addr);
        end
      end
      else if (instr_req_o)
      begin
        if (gnt_wait == 0)
          gnt_wait = rand_bits(2) + 1;  // New request
        gnt_wait--;
        if (gnt_wait == 0)
        begin
          instr_gnt_i = 1'b1;
          req_addr    = instr_addr_o;
          rv_wait     = rand_bits(2) + 1;
          if (exp_fetch_q.size() != 0)
            check_addr($sformatf("fetch address #%0d", fetch_n), exp_fetch_q.pop_front(),
                       req_addr);
          else
          begin
            check_addr("halt loop fetch address", HALT_ADDR, req_addr);
            halt_seen = 1'b1;  // Halt branch looped back to itself
          end
          fetch_n++;
        end
      end
    end
  end

  ////////////////////
  // Data memory
  ////////////////////
  initial
  begin : dmem_model
    int unsigned     gnt_wait;
    int unsigned     rv_wait;
    int unsigned     acc_n;
    logic            exp_we;
    logic [XLEN-1:0] exp_wdata;
    logic [XLEN-1:0] rd_word;
    gnt_wait      = 0;
    rv_wait       = 0;
    acc_n         = 0;
    rd_word       = '0;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i  = '0;
    forever
    begin
      @(posedge clk);
      #1;
      data_gnt_i    = 1'b0;
      data_rvalid_i = 1'b0;
      if (rv_wait != 0)
      begin
        rv_wait--;
        if (rv_wait == 0)
        begin
          data_rvalid_i = 1'b1;  // Stores get rvalid too
          data_rdata_i  = rd_word;
        end
      end
      else if (data_req_o)
      begin
        if (gnt_wait == 0)
          gnt_wait = rand_bits(2) + 1;
        gnt_wait--;
        if (gnt_wait == 0)
        begin
          data_gnt_i = 1'b1;
          rv_wait    = rand_bits(2) + 1;
          if (exp_addr_q.size() == 0)
            report_fail("Core made a data access that the program does not contain");
          else
          begin
            exp_we    = exp_we_q.pop_front();
            exp_wdata = exp_wdata_q.pop_front();
            check_addr($sformatf("data address #%0d", acc_n), exp_addr_q.pop_front(),
                       data_addr_o);
            check_bit($sformatf("data write enable #%0d", acc_n), exp_we, data_we_o);
            if (exp_we)
            begin
              check_word($sformatf("store data #%0d", acc_n), exp_wdata, data_wdata_o);
              rd_word = '0;
            end
            else
              rd_word = load_data_q.pop_front();
          end
          acc_n++;
        end
      end
    end
  end

  // Cycle limit and assertion watch
  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES)
      report_fail("Timeout: core hung before reaching the halt loop");
    else if (dut_i.sva_i.fail_count != 0)
      report_fail("Protocol assertion failed on a memory port");
  end

  ////////////////////
  // Main sequence
  ////////////////////
  initial
  begin
    rst_n          = 1'b0;
    fetch_enable_i = 1'b0;
    boot_addr_i    = BOOT_ADDR;
    build_program();
    run_model();
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    check_bit("instr_req_o after reset", 1'b0, instr_req_o);
    check_bit("data_req_o after reset", 1'b0, data_req_o);
    check_bit("core_busy_o after reset", 1'b0, core_busy_o);
    fetch_enable_i = 1'b1;
    wait (halt_seen);
    check_bit("core_busy_o in halt loop", 1'b1, core_busy_o);
    if (exp_addr_q.size() != 0)
      report_fail("Halt loop reached with data accesses still missing");
    else if (dut_i.sva_i.fail_count != 0)
      report_fail("Protocol assertion failed on a memory port");
    else
    begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* bench/tb_rv_mini_core_sva.sv */
////////////////////
// Memory port protocol checks, bound into rv_mini_core
// One access outstanding per port, request and address held until grant
// fail_count counts failed assertions
////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_rv_mini_core_sva
  import rv_core_pkg::*;
(
  input logic            clk,
  input logic            rst_n,
  input logic            instr_req_i,
  input logic [XLEN-1:0] instr_addr_i,
  input logic            instr_gnt_i,
  input logic            instr_rvalid_i,
  input logic            data_req_i,
  input logic [XLEN-1:0] data_addr_i,
  input logic            data_we_i,
  input logic [XLEN-1:0] data_wdata_i,
  input logic            data_gnt_i,
  input logic            data_rvalid_i
);

  int unsigned fail_count = 0;
  logic        instr_pend_q;  // Granted, rvalid not yet seen
  logic        data_pend_q;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      instr_pend_q <= 1'b0;
      data_pend_q  <= 1'b0;
    end
    else
    begin
      if (instr_req_i && instr_gnt_i)
        instr_pend_q <= 1'b1;
      else if (instr_rvalid_i)
        instr_pend_q <= 1'b0;
      if (data_req_i && data_gnt_i)
        data_pend_q <= 1'b1;
      else if (data_rvalid_i)
        data_pend_q <= 1'b0;
    end
  end

  instr_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_i && !instr_gnt_i |=> instr_req_i && $stable(instr_addr_i))
    else
    begin
      fail_count++;
      $error("Instruction request or address changed before grant");
    end

  data_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    data_req_i && !data_gnt_i |=> data_req_i && $stable(data_addr_i) &&
                                  $stable(data_we_i) && $stable(data_wdata_i))
    else
    begin
      fail_count++;
      $error("Data request, address or write data changed before grant");
    end

  // Second request while one is outstanding
  single_outstanding_a: assert property (@(posedge clk) disable iff (!rst_n)
    !(instr_pend_q && instr_req_i) && !(data_pend_q && data_req_i))
    else
    begin
      fail_count++;
      $error("Memory port requested with an access still outstanding");
    end

  req_known_a: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown({instr_req_i, data_req_i}))
    else
    begin
      fail_count++;
      $error("Request output unknown after reset");
    end

endmodule

bind rv_mini_core tb_rv_mini_core_sva sva_i (
  .clk            ( clk            ),
  .rst_n          ( rst_n          ),
  .instr_req_i    ( instr_req_o    ),
  .instr_addr_i   ( instr_addr_o   ),
  .instr_gnt_i    ( instr_gnt_i    ),
  .instr_rvalid_i ( instr_rvalid_i ),
  .data_req_i     ( data_req_o     ),
  .data_addr_i    ( data_addr_o    ),
  .data_we_i      ( data_we_o      ),
  .data_wdata_i   ( data_wdata_o   ),
  .data_gnt_i     ( data_gnt_i     ),
  .data_rvalid_i  ( data_rvalid_i  )
);

`default_nettype wire

/* design/rv_core_if.sv */
////////////////////
// Internal buses of the mini core
// instr_valid, pc_load, req and done are single-cycle pulses
// Fetch holds instr and pc stable until the next pc_load
////////////////////
`timescale 1ns/1ns
`default_nettype none

// Fetch unit <-> decode/execute
interface rv_fetch_if
  import rv_core_pkg::*;
();
  rv_instr_u       instr;        // Captured instruction word
  logic [XLEN-1:0] pc;           // Address of instr
  logic            instr_valid;  // Word ready, one pulse
  logic [XLEN-1:0] next_pc;
  logic            pc_load;      // Retire, starts next fetch

  modport fetch (output instr, pc, instr_valid, input next_pc, pc_load);
  modport exec  (input instr, pc, instr_valid, output next_pc, pc_load);
endinterface

// Decode/execute <-> load/store unit
interface rv_mem_if
  import rv_core_pkg::*;
();
  logic            req;    // Start pulse
  logic            we;
  logic [XLEN-1:0] addr;
  logic [XLEN-1:0] wdata;
  logic            done;   // Access complete, one pulse
  logic [XLEN-1:0] rdata;  // Load data, valid with done

  modport exec (output req, we, addr, wdata, input done, rdata);
  modport lsu  (input req, we, addr, wdata, output done, rdata);
endinterface

`default_nettype wire

/* design/rv_core_pkg.sv */
////////////////////
// Widths, RV32I encodings and FSM codes shared by the mini core units
// Only the executed subset (LUI, ADDI, ADD/SUB/AND/OR/XOR, BEQ/BNE, LW/SW)
// has constants here; anything else decodes as a no-op
////////////////////
`default_nettype none

package rv_core_pkg;

  localparam int unsigned XLEN       = 32;  // Data and address width
  localparam int unsigned REG_ADDR_W = 5;   // 32 architectural registers

  // Major opcodes
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  // funct3 codes in use
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;
  localparam logic [2:0] F3_WORD    = 3'b010;  // LW / SW

  localparam logic [6:0] F7_SUB     = 7'b0100000;

  // Memory port FSM, shared by fetch and LSU
  localparam logic [1:0] MS_IDLE = 2'd0;
  localparam logic [1:0] MS_REQ  = 2'd1;  // Request up, waiting for grant
  localparam logic [1:0] MS_WAIT = 2'd2;  // Granted, waiting for rvalid
  localparam logic [1:0] MS_EXEC = 2'd3;  // Fetch only: word handed to execute

  // Execute FSM
  localparam logic [1:0] EX_DECODE = 2'd0;
  localparam logic [1:0] EX_MEM    = 2'd1;
  localparam logic [1:0] EX_WB     = 2'd2;

  ////////////////////
  // Instruction formats, all over the same 32-bit word
  ////////////////////
  typedef struct packed {
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]           imm;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]            imm_hi;  // imm[11:5]
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [4:0]            imm_lo;  // imm[4:0]
    logic [6:0]            opcode;
  } s_fmt_t;

  typedef struct packed {
    logic                  imm12;
    logic [5:0]            imm10_5;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [3:0]            imm4_1;
    logic                  imm11;
    logic [6:0]            opcode;
  } b_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
  } rv_instr_u;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

endpackage

`default_nettype wire

/* design/rv_decode_exec.sv */
////////////////////
// Decode, ALU, branch and write-back for one instruction at a time
// Relies on fetch holding instr and pc until pc_load
// Unknown opcodes and funct codes retire without side effects
////////////////////
`timescale 1ns/1ns
`default_nettype none

module rv_decode_exec
  import rv_core_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  rv_fetch_if.exec fetch,
  rv_mem_if.exec   mem
);

  rv_instr_u       instr;
  logic [6:0]      opcode;
  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u;
  logic [XLEN-1:0] rs1_data, rs2_data;
  logic [XLEN-1:0] alu_b, alu_result;
  alu_op_e         alu_op;
  logic            wr_alu, is_load, is_store, is_branch, is_mem, taken;
  logic [1:0]      state_q;
  logic [XLEN-1:0] load_q;
  logic            rf_we;
  logic [XLEN-1:0] rf_wdata;

  assign instr  = fetch.instr;
  assign opcode = instr.r_fmt.opcode;

  ////////////////////
  // Immediates
  ////////////////////
  assign imm_i = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
  assign imm_s = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
  assign imm_b = {{19{instr.b_fmt.imm12}}, instr.b_fmt.imm12, instr.b_fmt.imm11,
                  instr.b_fmt.imm10_5, instr.b_fmt.imm4_1, 1'b0};
  // U-type is bits [31:12], spread over the I-format fields
  assign imm_u = {instr.i_fmt.imm, instr.i_fmt.rs1, instr.i_fmt.funct3, 12'b0};

  always_comb
  begin
    alu_op    = ALU_ADD;
    alu_b     = rs2_data;
    wr_alu    = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_branch = 1'b0;
    case (opcode)
      OPC_LUI:
      begin
        alu_op = ALU_PASS_B;
        alu_b  = imm_u;
        wr_alu = 1'b1;
      end
      OPC_OPIMM:
      begin
        alu_b  = imm_i;
        wr_alu = (instr.i_fmt.funct3 == F3_ADD_SUB);  // ADDI only
      end
      OPC_OP:
      begin
        // funct7 must be zero, or SUB
        wr_alu = (instr.r_fmt.funct7 == 7'b0) ||
                 (instr.r_fmt.funct3 == F3_ADD_SUB && instr.r_fmt.funct7 == F7_SUB);
        case (instr.r_fmt.funct3)
          F3_ADD_SUB: alu_op = (instr.r_fmt.funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
          F3_XOR:     alu_op = ALU_XOR;
          F3_OR:      alu_op = ALU_OR;
          F3_AND:     alu_op = ALU_AND;
          default:    wr_alu = 1'b0;  // SLL, SLT etc. not supported
        endcase
      end
      OPC_BRANCH:
      begin
        alu_op    = ALU_XOR;  // Zero result means equal
        is_branch = (instr.b_fmt.funct3 == F3_BEQ) || (instr.b_fmt.funct3 == F3_BNE);
      end
      OPC_LOAD:
      begin
        alu_b   = imm_i;  // Address = rs1 + imm
        is_load = (instr.i_fmt.funct3 == F3_WORD);
      end
      OPC_STORE:
      begin
        alu_b    = imm_s;
        is_store = (instr.s_fmt.funct3 == F3_WORD);
      end
      default: ;  // No-op
    endcase
  end

  assign is_mem = is_load || is_store;

  ////////////////////
  // ALU and branch
  ////////////////////
  always_comb
  begin
    case (alu_op)
      ALU_ADD: alu_result = rs1_data + alu_b;
      ALU_SUB: alu_result = rs1_data - alu_b;
      ALU_XOR: alu_result = rs1_data ^ alu_b;
      ALU_OR:  alu_result = rs1_data | alu_b;
      ALU_AND: alu_result = rs1_data & alu_b;
      default: alu_result = alu_b;  // PASS_B for LUI
    endcase
  end

  // BEQ taken on equal, BNE on not equal
  assign taken = is_branch && ((alu_result == '0) == (instr.b_fmt.funct3 == F3_BEQ));

  assign fetch.next_pc = taken ? fetch.pc + imm_b : fetch.pc + XLEN'(4);

  // Memory ops wait for done, then one write-back cycle
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      state_q <= EX_DECODE;
    else
    begin
      case (state_q)
        EX_DECODE:
          if (fetch.instr_valid && is_mem)
            state_q <= EX_MEM;
        EX_MEM:
          if (mem.done)
            state_q <= EX_WB;
        default:
          state_q <= EX_DECODE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (mem.done)
      load_q <= mem.rdata;
  end

  assign mem.req   = fetch.instr_valid && is_mem;
  assign mem.we    = is_store;
  assign mem.addr  = alu_result;
  assign mem.wdata = rs2_data;

  assign fetch.pc_load = (fetch.instr_valid && !is_mem) || (state_q == EX_WB);

  assign rf_we    = (fetch.instr_valid && wr_alu) || (state_q == EX_WB && is_load);
  assign rf_wdata = (state_q == EX_WB) ? load_q : alu_result;

  rv_regfile regfile_i (
    .clk       ( clk               ),
    .rst_n     ( rst_n             ),
    .raddr_a_i ( instr.r_fmt.rs1   ),
    .raddr_b_i ( instr.r_fmt.rs2   ),
    .waddr_i   ( instr.r_fmt.rd    ),
    .we_i      ( rf_we             ),
    .wdata_i   ( rf_wdata          ),
    .rdata_a_o ( rs1_data          ),
    .rdata_b_o ( rs2_data          )
  );

endmodule

`default_nettype wire

/* design/rv_fetch_unit.sv */
////////////////////
// Instruction fetch, one access outstanding at a time
// boot_addr_i is sampled only before the first request
// No new fetch starts until execute pulses pc_load
////////////////////
`timescale 1ns/1ns
`default_nettype none

module rv_fetch_unit
  import rv_core_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic [XLEN-1:0] boot_addr_i,
  input  logic            fetch_enable_i,
  output logic            instr_req_o,
  output logic [XLEN-1:0] instr_addr_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  input  logic [XLEN-1:0] instr_rdata_i,
  rv_fetch_if.fetch       fetch,
  output logic            busy_o
);

  logic [1:0]      state_q;
  logic [1:0]      state_d;
  logic [XLEN-1:0] pc_q;
  logic            booted_q;  // First request issued
  logic            valid_q;
  rv_instr_u       instr_q;
  logic            rdata_hit;

  assign rdata_hit = (state_q == MS_WAIT) && instr_rvalid_i;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      MS_IDLE:
        if (fetch_enable_i)
          state_d = MS_REQ;
      MS_REQ:
        if (instr_gnt_i)
          state_d = MS_WAIT;  // Request drops next cycle
      MS_WAIT:
        if (instr_rvalid_i)
          state_d = MS_EXEC;
      default:  // MS_EXEC, wait for retire
        if (fetch.pc_load)
          state_d = fetch_enable_i ? MS_REQ : MS_IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q  <= MS_IDLE;
      pc_q     <= '0;
      booted_q <= 1'b0;
      valid_q  <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      valid_q <= rdata_hit;  // One cycle after rvalid
      if (state_q == MS_IDLE && !booted_q)
        pc_q <= boot_addr_i;  // Track boot address until start
      else if (fetch.pc_load)
        pc_q <= fetch.next_pc;
      if (state_q == MS_REQ)
        booted_q <= 1'b1;
    end
  end

  // Instruction register
  always_ff @(posedge clk)
  begin
    if (rdata_hit)
      instr_q <= instr_rdata_i;
  end

  assign instr_req_o       = (state_q == MS_REQ);
  assign instr_addr_o      = pc_q;  // Stable while request is up
  assign fetch.instr       = instr_q;
  assign fetch.pc          = pc_q;
  assign fetch.instr_valid = valid_q;
  assign busy_o            = (state_q != MS_IDLE);

endmodule

`default_nettype wire

/* design/rv_load_store_unit.sv */
////////////////////
// Word-only data port, one access outstanding
// rvalid is expected for stores too
// req is ignored while an access is in progress
////////////////////
`timescale 1ns/1ns
`default_nettype none

module rv_load_store_unit
  import rv_core_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  rv_mem_if.lsu           mem,
  output logic            data_req_o,
  output logic [XLEN-1:0] data_addr_o,
  output logic            data_we_o,
  output logic [XLEN-1:0] data_wdata_o,
  input  logic            data_gnt_i,
  input  logic            data_rvalid_i,
  input  logic [XLEN-1:0] data_rdata_i
);

  logic [1:0]      state_q;
  logic            we_q;
  logic            done_q;
  logic [XLEN-1:0] addr_q, wdata_q, rdata_q;
  logic            start;

  assign start = (state_q == MS_IDLE) && mem.req;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= MS_IDLE;
      we_q    <= 1'b0;
      done_q  <= 1'b0;
    end
    else
    begin
      done_q <= (state_q == MS_WAIT) && data_rvalid_i;  // Cycle after rvalid
      case (state_q)
        MS_IDLE:
        begin
          if (mem.req)
          begin
            state_q <= MS_REQ;
            we_q    <= mem.we;
          end
        end
        MS_REQ:
          if (data_gnt_i)
            state_q <= MS_WAIT;
        MS_WAIT:
          if (data_rvalid_i)
            state_q <= MS_IDLE;
        default:
          state_q <= MS_IDLE;
      endcase
    end
  end

  // Address and data held until grant
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      addr_q  <= mem.addr;
      wdata_q <= mem.wdata;
    end
    if (state_q == MS_WAIT && data_rvalid_i)
      rdata_q <= data_rdata_i;
  end

  assign data_req_o   = (state_q == MS_REQ);
  assign data_addr_o  = addr_q;
  assign data_we_o    = we_q;
  assign data_wdata_o = wdata_q;
  assign mem.done     = done_q;
  assign mem.rdata    = rdata_q;

endmodule

`default_nettype wire

/* design/rv_mini_core.sv */
////////////////////
// RV32I subset core top, fetch -> execute -> memory, no overlap
// Both ports use req/gnt/rvalid, one access outstanding each
// No byte enables, all data accesses are full words
////////////////////
`timescale 1ns/1ns
`default_nettype none

module rv_mini_core
  import rv_core_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic [XLEN-1:0] boot_addr_i,
  input  logic            fetch_enable_i,

  // Instruction memory
  output logic            instr_req_o,
  output logic [XLEN-1:0] instr_addr_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  input  logic [XLEN-1:0] instr_rdata_i,

  // Data memory
  output logic            data_req_o,
  output logic [XLEN-1:0] data_addr_o,
  output logic            data_we_o,
  output logic [XLEN-1:0] data_wdata_o,
  input  logic            data_gnt_i,
  input  logic            data_rvalid_i,
  input  logic [XLEN-1:0] data_rdata_i,

  output logic            core_busy_o
);

  rv_fetch_if fetch_bus ();
  rv_mem_if   mem_bus ();

  ////////////////////
  // Input side
  ////////////////////
  rv_fetch_unit fetch_unit_i (
    .clk            ( clk            ),
    .rst_n          ( rst_n          ),
    .boot_addr_i    ( boot_addr_i    ),
    .fetch_enable_i ( fetch_enable_i ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .fetch          ( fetch_bus      ),
    .busy_o         ( core_busy_o    )  // Idle only at an instruction boundary
  );

  rv_decode_exec decode_exec_i (
    .clk   ( clk       ),
    .rst_n ( rst_n     ),
    .fetch ( fetch_bus ),
    .mem   ( mem_bus   )
  );

  ////////////////////
  // Output side
  ////////////////////
  rv_load_store_unit load_store_unit_i (
    .clk           ( clk           ),
    .rst_n         ( rst_n         ),
    .mem           ( mem_bus       ),
    .data_req_o    ( data_req_o    ),
    .data_addr_o   ( data_addr_o   ),
    .data_we_o     ( data_we_o     ),
    .data_wdata_o  ( data_wdata_o  ),
    .data_gnt_i    ( data_gnt_i    ),
    .data_rvalid_i ( data_rvalid_i ),
    .data_rdata_i  ( data_rdata_i  )
  );

endmodule

`default_nettype wire

/* design/rv_regfile.sv */
////////////////////
// 32 x 32 register file, 2 read / 1 write
// Reads are combinational, x0 reads as zero
////////////////////
`timescale 1ns/1ns
`default_nettype none

module rv_regfile
  import rv_core_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [REG_ADDR_W-1:0] raddr_a_i,
  input  logic [REG_ADDR_W-1:0] raddr_b_i,
  input  logic [REG_ADDR_W-1:0] waddr_i,
  input  logic                  we_i,
  input  logic [XLEN-1:0]       wdata_i,
  output logic [XLEN-1:0]       rdata_a_o,
  output logic [XLEN-1:0]       rdata_b_o
);

  logic [XLEN-1:0] regs_q [1:2**REG_ADDR_W-1];  // No storage for x0

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 1; i < 2**REG_ADDR_W; i++)
        regs_q[i] <= '0;
    end
    else if (we_i && waddr_i != '0)  // x0 writes dropped
      regs_q[waddr_i] <= wdata_i;
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

/* rv_mini_core.f */
design/rv_core_pkg.sv
design/rv_core_if.sv
design/rv_fetch_unit.sv
design/rv_regfile.sv
design/rv_decode_exec.sv
design/rv_load_store_unit.sv
design/rv_mini_core.sv
bench/tb_rv_mini_core_sva.sv
bench/tb_rv_mini_core.sv
